//--- carry_resolver.f
+incdir+include
src/carry_pkg.sv
src/carry_classify.sv
src/carry_run_tracker.sv
src/byte_release_queue.sv
src/carry_resolver.sv
tests/tb_carry_resolver.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_carry_resolver \
    -Mdir obj_dir -f carry_resolver.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_carry_resolver > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- src/byte_release_queue.sv
`timescale 1ns/10ps

module byte_release_queue #(
    parameter int QUEUE_ADDR_W = 5,
    parameter int RUN_W        = 4,
    parameter int OUT_LANES    = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rel_valid,
    input  logic                             rel_head_valid,
    input  carry_pkg::byte_t                 rel_head,
    input  carry_pkg::byte_t                 rel_fill,
    input  logic [RUN_W-1:0]                 rel_fill_count,
    output logic                             out_valid,
    output logic [$clog2(OUT_LANES+1)-1:0]   out_count,
    output carry_pkg::byte_t                 out_bytes [OUT_LANES]
);
    import carry_pkg::*;

    localparam int DEPTH   = 2 ** QUEUE_ADDR_W;
    localparam int OCC_W   = QUEUE_ADDR_W + 1;
    localparam int CNT_W   = $clog2(OUT_LANES + 1);
    // One head byte plus the longest fill run
    localparam int MAX_REL = 2 ** RUN_W;

    byte_t                   mem [DEPTH];
    logic [QUEUE_ADDR_W-1:0] wr_ptr;
    logic [QUEUE_ADDR_W-1:0] rd_ptr;
    logic [OCC_W-1:0]        occupancy;

    logic [RUN_W:0]          wr_len;
    logic [CNT_W-1:0]        rd_n;

    // ========================================================================
    // Write side
    // ========================================================================
    assign wr_len = rel_valid ?
                    ((RUN_W+1)'(rel_fill_count) + (RUN_W+1)'(rel_head_valid)) : '0;

    // Head byte first, then the fill copies, all in one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_REL; i++) begin
            if ((RUN_W+1)'(i) < wr_len) begin
                if ((i == 0) && rel_head_valid) begin
                    mem[wr_ptr + QUEUE_ADDR_W'(i)] <= rel_head;
                end else begin
                    mem[wr_ptr + QUEUE_ADDR_W'(i)] <= rel_fill;
                end
            end
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================
    // Oldest bytes first, at most one beat of lanes
    assign rd_n = (occupancy >= OCC_W'(OUT_LANES)) ? CNT_W'(OUT_LANES) : CNT_W'(occupancy);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            wr_ptr    <= wr_ptr + QUEUE_ADDR_W'(wr_len);
            rd_ptr    <= rd_ptr + QUEUE_ADDR_W'(rd_n);
            occupancy <= occupancy + OCC_W'(wr_len) - OCC_W'(rd_n);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_count <= '0;
        end else begin
            out_valid <= (rd_n != '0);
            out_count <= rd_n;
        end
    end

    // Unused lanes are zeroed so a short beat is easy to read
    always_ff @(posedge clk) begin
        for (int l = 0; l < OUT_LANES; l++) begin
            if (CNT_W'(l) < rd_n) begin
                out_bytes[l] <= mem[rd_ptr + QUEUE_ADDR_W'(l)];
            end else begin
                out_bytes[l] <= '0;
            end
        end
    end

    // No back-pressure upstream, so a release must always fit
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        rel_valid |-> (OCC_W'(wr_len) <= (OCC_W'(DEPTH) - occupancy)))
        else $error("release command larger than the free queue space");

endmodule

//--- src/carry_classify.sv
`timescale 1ns/10ps

module carry_classify (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 flush,
    input  carry_pkg::code_word_t in_word,
    output logic                 item_valid,
    output carry_pkg::item_kind_t item_kind,
    output carry_pkg::byte_t     item_byte
);
    import carry_pkg::*;

    logic       has_carry;
    logic       is_ff;
    item_kind_t next_kind;

    // Anything above the low byte is a carry into earlier bytes
    assign has_carry = |in_word[WORD_W-1:BYTE_W];
    assign is_ff     = (in_word[BYTE_W-1:0] == FF_BYTE);

    always_comb begin
        if (flush) begin
            next_kind = KIND_FLUSH;
        end else if (has_carry) begin
            next_kind = KIND_CARRY;
        end else if (is_ff) begin
            next_kind = KIND_HOLD;
        end else begin
            next_kind = KIND_PLAIN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
        end else begin
            item_valid <= in_valid || flush;
        end
    end

    // Kind and byte are qualified by item_valid
    always_ff @(posedge clk) begin
        if (in_valid || flush) begin
            item_kind <= next_kind;
            item_byte <= in_word[BYTE_W-1:0];
        end
    end

    // The encoder never flushes while delivering a word
    a_flush_alone: assert property (@(posedge clk) disable iff (reset)
        !(in_valid && flush))
        else $error("flush and in_valid asserted in the same cycle");

endmodule

//--- src/carry_pkg.sv
package carry_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int BYTE_W = 8;
    localparam int WORD_W = 16;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] code_word_t;

    // An all-ones byte may still absorb a carry, so it is held back
    localparam byte_t FF_BYTE   = 8'hFF;
    // What a held 0xFF turns into once the carry ripples through it
    localparam byte_t ZERO_BYTE = 8'h00;

    // ========================================================================
    // Classified input item
    // ========================================================================
    typedef enum logic [1:0] {
        // No carry, byte not 0xFF
        KIND_PLAIN = 2'b00,
        // No carry, byte is 0xFF
        KIND_HOLD  = 2'b01,
        // Upper part of the word is nonzero
        KIND_CARRY = 2'b10,
        // Release all held bytes
        KIND_FLUSH = 2'b11
    } item_kind_t;

endpackage

//--- src/carry_resolver.sv
`timescale 1ns/10ps

module carry_resolver #(
    parameter int RUN_W        = 4,
    parameter int QUEUE_ADDR_W = 5,
    parameter int OUT_LANES    = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic                           flush,
    input  carry_pkg::code_word_t          in_word,
    output logic                           out_valid,
    output logic [$clog2(OUT_LANES+1)-1:0] out_count,
    output carry_pkg::byte_t               out_bytes [OUT_LANES]
);
    import carry_pkg::*;

    // Decode to execute
    logic             item_valid;
    item_kind_t       item_kind;
    byte_t            item_byte;

    // Execute to result
    logic             rel_valid;
    logic             rel_head_valid;
    byte_t            rel_head;
    byte_t            rel_fill;
    logic [RUN_W-1:0] rel_fill_count;

    // ========================================================================
    // Three-stage pipeline
    // ========================================================================
    carry_classify u_classify (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .flush      (flush),
        .in_word    (in_word),
        .item_valid (item_valid),
        .item_kind  (item_kind),
        .item_byte  (item_byte)
    );

    carry_run_tracker #(
        .RUN_W (RUN_W)
    ) u_tracker (
        .clk            (clk),
        .reset          (reset),
        .item_valid     (item_valid),
        .item_kind      (item_kind),
        .item_byte      (item_byte),
        .rel_valid      (rel_valid),
        .rel_head_valid (rel_head_valid),
        .rel_head       (rel_head),
        .rel_fill       (rel_fill),
        .rel_fill_count (rel_fill_count)
    );

    byte_release_queue #(
        .QUEUE_ADDR_W (QUEUE_ADDR_W),
        .RUN_W        (RUN_W),
        .OUT_LANES    (OUT_LANES)
    ) u_queue (
        .clk            (clk),
        .reset          (reset),
        .rel_valid      (rel_valid),
        .rel_head_valid (rel_head_valid),
        .rel_head       (rel_head),
        .rel_fill       (rel_fill),
        .rel_fill_count (rel_fill_count),
        .out_valid      (out_valid),
        .out_count      (out_count),
        .out_bytes      (out_bytes)
    );

endmodule

//--- src/carry_run_tracker.sv
`timescale 1ns/10ps

module carry_run_tracker #(
    parameter int RUN_W = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  item_valid,
    input  carry_pkg::item_kind_t item_kind,
    input  carry_pkg::byte_t      item_byte,
    output logic                  rel_valid,
    output logic                  rel_head_valid,
    output carry_pkg::byte_t      rel_head,
    output carry_pkg::byte_t      rel_fill,
    output logic [RUN_W-1:0]      rel_fill_count
);
    import carry_pkg::*;

    // Last byte that was not 0xFF, and the 0xFF run behind it
    logic             pending_valid;
    byte_t            pending_byte;
    logic [RUN_W-1:0] run_cnt;

    logic             has_held;
    logic             do_release;
    byte_t            next_head;
    byte_t            next_fill;

    assign has_held = pending_valid || (run_cnt != '0);

    // ========================================================================
    // Release decision
    // ========================================================================
    always_comb begin
        do_release = 1'b0;
        next_head  = pending_byte;
        next_fill  = FF_BYTE;
        if (item_valid) begin
            case (item_kind)
                KIND_PLAIN, KIND_FLUSH: begin
                    // No carry came, held bytes go out unchanged
                    do_release = has_held;
                end
                KIND_CARRY: begin
                    // Carry stops at the pending byte, the 0xFF run wraps to zero
                    do_release = 1'b1;
                    next_head  = pending_byte + byte_t'(1);
                    next_fill  = ZERO_BYTE;
                end
                default: begin
                    do_release = 1'b0;
                end
            endcase
        end
    end

    // ========================================================================
    // Held state
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_valid <= 1'b0;
            run_cnt       <= '0;
        end else if (item_valid) begin
            case (item_kind)
                KIND_HOLD: run_cnt <= run_cnt + 1'b1;
                KIND_FLUSH: begin
                    pending_valid <= 1'b0;
                    run_cnt       <= '0;
                end
                default: begin
                    pending_valid <= 1'b1;
                    run_cnt       <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (item_valid && ((item_kind == KIND_PLAIN) || (item_kind == KIND_CARRY))) begin
            pending_byte <= item_byte;
        end
    end

    // Release command register
    always_ff @(posedge clk) begin
        if (reset) begin
            rel_valid <= 1'b0;
        end else begin
            rel_valid <= do_release;
        end
    end

    always_ff @(posedge clk) begin
        if (do_release) begin
            rel_head_valid <= pending_valid;
            rel_head       <= next_head;
            rel_fill       <= next_fill;
            rel_fill_count <= run_cnt;
        end
    end

    a_run_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (item_valid && (item_kind == KIND_HOLD)) |-> (run_cnt != '1))
        else $error("0xFF run longer than the run counter can hold");

    a_carry_has_pending: assert property (@(posedge clk) disable iff (reset)
        (item_valid && (item_kind == KIND_CARRY)) |-> pending_valid)
        else $error("carry arrived with no pending byte");

endmodule

//--- include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Reference model of the carry rule, fed with every driven word
logic        model_pending_valid;
byte_t       model_pending;
int          model_run;
byte_t       exp_q [$];
logic [15:0] lfsr_state;

// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[14:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// Held bytes go out unchanged, or bumped by one with the run wrapped to zero
function automatic void release_held(input logic carry);
    if (model_pending_valid) begin
        exp_q.push_back(carry ? model_pending + 8'd1 : model_pending);
    end
    for (int i = 0; i < model_run; i++) begin
        exp_q.push_back(carry ? 8'h00 : 8'hFF);
    end
endfunction

function automatic void predict_word(input logic [15:0] w);
    if ((w[15:8] == 8'h00) && (w[7:0] == 8'hFF)) begin
        model_run++;
    end else begin
        release_held(w[15:8] != 8'h00);
        model_pending_valid = 1'b1;
        model_pending       = w[7:0];
        model_run           = 0;
    end
endfunction

// Flush releases without carry and leaves nothing held
function automatic void predict_flush();
    release_held(1'b0);
    model_pending_valid = 1'b0;
    model_run           = 0;
endfunction

`endif

//--- tests/tb_carry_resolver.sv
`timescale 1ns/10ps

module tb_carry_resolver;
    import carry_pkg::*;

    localparam int RUN_W         = 4;
    localparam int QUEUE_ADDR_W  = 5;
    localparam int OUT_LANES     = 4;
    localparam int CNT_W         = $clog2(OUT_LANES + 1);
    localparam int MAX_RUN       = 2 ** RUN_W - 1;
    localparam int RANDOM_WORDS  = 400;
    localparam int DRAIN_TIMEOUT = 100;

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic             flush;
    code_word_t       in_word;
    logic             out_valid;
    logic [CNT_W-1:0] out_count;
    byte_t            out_bytes [OUT_LANES];

    int   mismatch_count;
    int   other_errors;
    int   beat_count;
    logic timed_out;

    `include "tb_ref_model.svh"

    carry_resolver #(
        .RUN_W        (RUN_W),
        .QUEUE_ADDR_W (QUEUE_ADDR_W),
        .OUT_LANES    (OUT_LANES)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .flush     (flush),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_count (out_count),
        .out_bytes (out_bytes)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // Every beat is checked against the front of the expected queue
    // ========================================================================
    always @(negedge clk) begin
        byte_t want;
        if (!reset && out_valid) begin
            beat_count++;
            assert ((out_count != '0) && (int'(out_count) <= OUT_LANES)) else begin
                other_errors++;
                $display("%0t: out_count %0d is outside 1 to %0d", $time, out_count, OUT_LANES);
            end
            for (int l = 0; l < OUT_LANES; l++) begin
                if (l >= int'(out_count)) begin
                    assert (out_bytes[l] == 8'h00) else begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: out_bytes[%0d] got %h expected 00",
                                 $time, l, out_bytes[l]);
                    end
                end else begin
                    assert (exp_q.size() != 0) else begin
                        other_errors++;
                        $display("%0t: out_bytes[%0d] = %h came out with no byte expected",
                                 $time, l, out_bytes[l]);
                    end
                    if (exp_q.size() != 0) begin
                        want = exp_q.pop_front();
                        assert (out_bytes[l] == want) else begin
                            mismatch_count++;
                            $display("MISMATCH at %0t: out_bytes[%0d] got %h expected %h",
                                     $time, l, out_bytes[l], want);
                        end
                    end
                end
            end
        end
    end

    task automatic send_word(input code_word_t w);
        in_valid = 1'b1;
        in_word  = w;
        predict_word(w);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_flush();
        flush = 1'b1;
        predict_flush();
        @(negedge clk);
        flush = 1'b0;
    endtask

    // Idle cycles after the drain catch any stray beat
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                timed_out = 1'b1;
                other_errors++;
                $display("%0t: timeout with %0d bytes still expected", $time, exp_q.size());
            end
        end
        repeat (4) @(negedge clk);
    endtask

    // Kinds, run lengths and gaps all come from the LFSR
    task automatic random_stream();
        logic [15:0] r;
        int          run_len;
        for (int n = 0; n < RANDOM_WORDS; n++) begin
            r = rand_bits(3);
            if ((r >= 4) && (r <= 5) && (model_run < MAX_RUN)) begin
                run_len = 1 + int'(rand_bits(4)) % (MAX_RUN - model_run);
                repeat (run_len) send_word(16'h00FF);
            end else if ((r >= 6) && model_pending_valid) begin
                r = rand_bits(16);
                send_word({(r[15:8] == 8'h00) ? 8'h01 : r[15:8],
                           (r[7:0] == 8'hFF) ? 8'hFE : r[7:0]});
            end else begin
                r = rand_bits(8);
                send_word({8'h00, (r[7:0] == 8'hFF) ? 8'hFE : r[7:0]});
            end
            if (rand_bits(2) == 16'd0) begin
                @(negedge clk);
            end
        end
        send_flush();
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        reset               = 1'b1;
        in_valid            = 1'b0;
        flush               = 1'b0;
        in_word             = '0;
        mismatch_count      = 0;
        other_errors        = 0;
        beat_count          = 0;
        timed_out           = 1'b0;
        lfsr_state          = 16'd85;
        model_pending_valid = 1'b0;
        model_pending       = '0;
        model_run           = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (!out_valid) else begin
            other_errors++;
            $display("%0t: out_valid high right after reset", $time);
        end

        // A lone plain word stays pending until the next word
        send_word(16'h0012);
        repeat (6) @(negedge clk);
        send_word(16'h0034);
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            send_word(16'h0021 + 16'(i * 5));
        end
        send_flush();
        wait_drain();

        // 0xFF run closed by a plain word, then a run closed by a carry
        send_word(16'h0040);
        repeat (5) send_word(16'h00FF);
        send_word(16'h0041);
        wait_drain();
        repeat (6) send_word(16'h00FF);
        send_word(16'h0133);
        send_word(16'h0150);
        send_flush();
        wait_drain();

        random_stream();
        wait_drain();

        $display("Beats checked: %0d, mismatches: %0d, other errors: %0d",
                 beat_count, mismatch_count, other_errors);
        if ((mismatch_count == 0) && (other_errors == 0) && !timed_out && (beat_count != 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
